//--- Makefile
# Verilator simulation of the host-memory read requester

VERILATOR ?= verilator
TOP       ?= hm_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/hm_pkg.sv
`default_nettype none

package hm_pkg;

  // AXI4-Lite register map, byte offsets
  localparam logic [7:0] reg_ctrl      = 8'h00; // Bit 0 start, bit 1 nosnoop
  localparam logic [7:0] reg_addr_lo   = 8'h04;
  localparam logic [7:0] reg_addr_hi   = 8'h08;
  localparam logic [7:0] reg_len_tag   = 8'h0C; // Length 9:0, tag 23:16
  localparam logic [7:0] reg_timeout   = 8'h10;
  localparam logic [7:0] reg_status    = 8'h14; // Busy 0, done 1, error 9:8
  localparam logic [7:0] reg_cnt_start = 8'h18;
  localparam logic [7:0] reg_cnt_done  = 8'h1C;
  localparam logic [7:0] reg_cnt_drop  = 8'h20;

  // TLP header field values
  localparam logic [2:0] fmt_3dw  = 3'b000; // 3DW header, no data
  localparam logic [2:0] fmt_4dw  = 3'b001; // 4DW header, no data
  localparam logic [4:0] type_mrd = 5'b00000; // Memory read request
  localparam logic [3:0] be_all   = 4'hf;

  // Statistics counter width
  localparam int cnt_w = 32;

  // Request as programmed through the register block
  typedef struct packed {
    logic [63:0] addr;
    logic [9:0]  len;     // In dwords, 0 means 1024
    logic [7:0]  tag;
    logic        nosnoop;
    logic [23:0] timeout; // Stall cycles before abort
  } hm_req_t;

  // First 64-bit beat of a Memory Read TLP
  typedef struct packed {
    logic [2:0]  fmt;
    logic [4:0]  tlp_type;
    logic [7:0]  tc_byte;   // TC0 only
    logic [3:0]  rsvd_attr; // Reserved 3:2, relaxed ordering 1, no snoop 0
    logic [1:0]  at;        // Default untranslated
    logic [9:0]  length;
    logic [15:0] req_id;    // Bus, device, function
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
  } tlp_mrd_hdr_t;

  // Request completion codes
  typedef enum logic [1:0] {
    err_ok     = 2'd0,
    err_no_rdy = 2'd1, // Link down or destination stalled too long
    err_busy   = 2'd2  // Start while a request is in flight
  } hm_err_t;

  // Transmit engine states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_send = 2'd1,
    st_done = 2'd2
  } tx_state_t;

endpackage

`default_nettype wire

//--- hdl/hm_regs.sv
`default_nettype none

module hm_regs
  import hm_pkg::*;
(
  input  logic             trn_clk,
  input  logic             reset,

  input  logic [7:0]       s_awaddr,
  input  logic             s_awvalid,
  output logic             s_awready,
  input  logic [31:0]      s_wdata,
  input  logic [3:0]       s_wstrb,
  input  logic             s_wvalid,
  output logic             s_wready,
  output logic [1:0]       s_bresp,
  output logic             s_bvalid,
  input  logic             s_bready,
  input  logic [7:0]       s_araddr,
  input  logic             s_arvalid,
  output logic             s_arready,
  output logic [31:0]      s_rdata,
  output logic [1:0]       s_rresp,
  output logic             s_rvalid,
  input  logic             s_rready,

  output hm_req_t          req,
  output logic             start,
  input  logic             busy,
  input  logic             done,
  input  logic             start_ok,
  input  hm_err_t          err,
  input  logic [cnt_w-1:0] cnt_start,
  input  logic [cnt_w-1:0] cnt_done,
  input  logic [cnt_w-1:0] cnt_drop
);

  logic        wr_en;
  logic        rd_en;
  logic        ctrl_wr;
  logic [31:0] addr_lo_q;
  logic [31:0] addr_hi_q;
  logic [9:0]  len_q;
  logic [7:0]  tag_q;
  logic [23:0] timeout_q;
  logic        nosnoop_q;
  logic        done_q;
  hm_err_t     err_q;
  logic [31:0] rd_mux;

  // Byte-lane merge for full word registers
  function automatic logic [31:0] strb_merge(input logic [31:0] cur,
                                             input logic [31:0] wd,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;
  assign rd_en     = s_arvalid && !s_rvalid;
  assign s_awready = wr_en;
  assign s_wready  = wr_en;
  assign s_arready = rd_en;
  assign s_bresp   = 2'b00; // Always OKAY
  assign s_rresp   = 2'b00;

  assign ctrl_wr = wr_en && (s_awaddr == reg_ctrl) && s_wstrb[0];
  assign start   = ctrl_wr && s_wdata[0];

  // Start write may carry nosnoop in the same word
  assign req.addr    = {addr_hi_q, addr_lo_q};
  assign req.len     = len_q;
  assign req.tag     = tag_q;
  assign req.nosnoop = (ctrl_wr && !busy) ? s_wdata[1] : nosnoop_q;
  assign req.timeout = timeout_q;

  // Configuration is frozen while a request is in flight
  always_ff @(posedge trn_clk) begin
    if (reset) begin
      addr_lo_q <= '0;
      addr_hi_q <= '0;
      len_q     <= '0;
      tag_q     <= '0;
      timeout_q <= '0;
      nosnoop_q <= 1'b0;
    end else if (wr_en && !busy) begin
      case (s_awaddr)
        reg_ctrl:    if (s_wstrb[0]) nosnoop_q <= s_wdata[1];
        reg_addr_lo: addr_lo_q <= strb_merge(addr_lo_q, s_wdata, s_wstrb);
        reg_addr_hi: addr_hi_q <= strb_merge(addr_hi_q, s_wdata, s_wstrb);
        reg_len_tag: begin
          if (s_wstrb[0]) len_q[7:0] <= s_wdata[7:0];
          if (s_wstrb[1]) len_q[9:8] <= s_wdata[9:8];
          if (s_wstrb[2]) tag_q      <= s_wdata[23:16];
        end
        reg_timeout: begin
          if (s_wstrb[0]) timeout_q[7:0]   <= s_wdata[7:0];
          if (s_wstrb[1]) timeout_q[15:8]  <= s_wdata[15:8];
          if (s_wstrb[2]) timeout_q[23:16] <= s_wdata[23:16];
        end
        default: ;
      endcase
    end
  end

  // Sticky status, a refused start keeps err_busy past the running request
  always_ff @(posedge trn_clk) begin
    if (reset) begin
      done_q <= 1'b0;
      err_q  <= err_ok;
    end else begin
      if (start) done_q <= 1'b0;
      if (start && busy) begin
        err_q <= err_busy;
      end else if (start_ok) begin
        err_q <= err_ok;
      end
      if (done) begin
        done_q <= 1'b1;
        if (err_q != err_busy) err_q <= err;
      end
    end
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      s_bvalid <= 1'b0;
    end else if (wr_en) begin
      s_bvalid <= 1'b1;
    end else if (s_bready) begin
      s_bvalid <= 1'b0;
    end
  end

  always_comb begin
    case (s_araddr)
      reg_ctrl:      rd_mux = {30'b0, nosnoop_q, 1'b0}; // Start reads back zero
      reg_addr_lo:   rd_mux = addr_lo_q;
      reg_addr_hi:   rd_mux = addr_hi_q;
      reg_len_tag:   rd_mux = {8'b0, tag_q, 6'b0, len_q};
      reg_timeout:   rd_mux = {8'b0, timeout_q};
      reg_status:    rd_mux = {22'b0, err_q, 6'b0, done_q, busy};
      reg_cnt_start: rd_mux = cnt_start;
      reg_cnt_done:  rd_mux = cnt_done;
      reg_cnt_drop:  rd_mux = cnt_drop;
      default:       rd_mux = 32'b0;
    endcase
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      s_rvalid <= 1'b0;
    end else if (rd_en) begin
      s_rvalid <= 1'b1;
    end else if (s_rready) begin
      s_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge trn_clk) begin
    if (rd_en) s_rdata <= rd_mux;
  end

endmodule

`default_nettype wire

//--- hdl/hm_stats.sv
`default_nettype none

module hm_stats
  import hm_pkg::*;
(
  input  logic             trn_clk,
  input  logic             reset,
  input  logic             start_ok,
  input  logic             sent,
  input  logic             trn_terr_drop_n,
  output logic [cnt_w-1:0] cnt_start,
  output logic [cnt_w-1:0] cnt_done,
  output logic [cnt_w-1:0] cnt_drop
);

  // Sticks at all ones
  function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] cnt,
                                               input logic             ev);
    logic [cnt_w-1:0] res;
    res = cnt;
    if (ev && (cnt != {cnt_w{1'b1}})) res = cnt + 1'b1;
    return res;
  endfunction

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      cnt_start <= '0;
      cnt_done  <= '0;
      cnt_drop  <= '0;
    end else begin
      cnt_start <= sat_inc(cnt_start, start_ok);
      cnt_done  <= sat_inc(cnt_done, sent);
      cnt_drop  <= sat_inc(cnt_drop, !trn_terr_drop_n); // One per low cycle
    end
  end

endmodule

`default_nettype wire

//--- hdl/hm_top.sv
`default_nettype none

module hm_top
  import hm_pkg::*;
(
  input  logic        trn_clk,
  input  logic        reset,

  input  logic [7:0]  s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [31:0] s_wdata,
  input  logic [3:0]  s_wstrb,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [7:0]  s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [31:0] s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready,

  input  logic [7:0]  cfg_bus_number,
  input  logic [4:0]  cfg_device_number,
  input  logic [2:0]  cfg_function_number,

  input  logic        trn_lnk_up_n,
  input  logic        trn_tdst_rdy_n,
  input  logic        trn_terr_drop_n,
  output logic [63:0] trn_td,
  output logic        trn_tsof_n,
  output logic        trn_teof_n,
  output logic        trn_trem_n,
  output logic        trn_tsrc_rdy_n,
  output logic        trn_cyc_n,
  output logic        trn_tstr_n,
  output logic        trn_terrfwd_n,
  output logic        trn_tsrc_dsc_n
);

  hm_req_t          req;
  hm_err_t          err;
  logic             start;
  logic             busy;
  logic             done;
  logic             start_ok;
  logic             sent;
  logic [cnt_w-1:0] cnt_start;
  logic [cnt_w-1:0] cnt_done;
  logic [cnt_w-1:0] cnt_drop;

  // Core tie-offs
  assign trn_tstr_n     = 1'b0; // Streaming allowed
  assign trn_terrfwd_n  = 1'b1;
  assign trn_tsrc_dsc_n = 1'b1;

  hm_regs regs_i (
    .trn_clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready,
    .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .req, .start, .busy, .done, .start_ok, .err,
    .cnt_start, .cnt_done, .cnt_drop
  );

  hm_tx tx_i (
    .trn_clk, .reset, .start, .req,
    .cfg_bus_number, .cfg_device_number, .cfg_function_number,
    .trn_lnk_up_n, .trn_tdst_rdy_n,
    .trn_td, .trn_tsof_n, .trn_teof_n, .trn_trem_n, .trn_tsrc_rdy_n, .trn_cyc_n,
    .busy, .done, .start_ok, .sent, .err
  );

  hm_stats stats_i (
    .trn_clk, .reset, .start_ok, .sent, .trn_terr_drop_n,
    .cnt_start, .cnt_done, .cnt_drop
  );

endmodule

`default_nettype wire

//--- hdl/hm_tx.sv
`default_nettype none

module hm_tx
  import hm_pkg::*;
(
  input  logic        trn_clk,
  input  logic        reset,
  input  logic        start,
  input  hm_req_t     req,
  input  logic [7:0]  cfg_bus_number,
  input  logic [4:0]  cfg_device_number,
  input  logic [2:0]  cfg_function_number,

  input  logic        trn_lnk_up_n,
  input  logic        trn_tdst_rdy_n,
  output logic [63:0] trn_td,
  output logic        trn_tsof_n,
  output logic        trn_teof_n,
  output logic        trn_trem_n,
  output logic        trn_tsrc_rdy_n,
  output logic        trn_cyc_n,

  output logic        busy,
  output logic        done,
  output logic        start_ok,
  output logic        sent,
  output hm_err_t     err
);

  tx_state_t    state;
  tlp_mrd_hdr_t hdr;
  logic [63:0]  beat_buf [2];
  logic         beat_idx;     // Advances only on a transfer
  logic         is_4dw;
  logic         is_4dw_q;
  logic [23:0]  timeout_q;
  logic [23:0]  stall_cnt;
  logic         stall_limit;
  logic         accept;

  assign is_4dw = (req.addr[63:32] != 32'b0);
  assign accept = (state == st_idle) && start && !trn_lnk_up_n;

  always_comb begin
    hdr.fmt       = is_4dw ? fmt_4dw : fmt_3dw;
    hdr.tlp_type  = type_mrd;
    hdr.tc_byte   = 8'h00;
    hdr.rsvd_attr = {3'b000, req.nosnoop};
    hdr.at        = 2'b00;
    hdr.length    = req.len;
    hdr.req_id    = {cfg_bus_number, cfg_device_number, cfg_function_number};
    hdr.tag       = req.tag;
    hdr.last_be   = be_all;
    hdr.first_be  = be_all;
  end

  // Both beats captured at start, 3DW puts the address in the upper dword
  always_ff @(posedge trn_clk) begin
    if (accept) begin
      beat_buf[0] <= hdr;
      beat_buf[1] <= is_4dw ? req.addr : {req.addr[31:0], 32'h0};
      is_4dw_q    <= is_4dw;
      timeout_q   <= req.timeout;
    end
  end

  // Counting this cycle reaches the limit
  assign stall_limit = ({1'b0, stall_cnt} + 25'd1) >= {1'b0, timeout_q};

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      state     <= st_idle;
      beat_idx  <= 1'b0;
      stall_cnt <= '0;
      done      <= 1'b0;
      start_ok  <= 1'b0;
      sent      <= 1'b0;
      err       <= err_ok;
    end else begin
      done     <= 1'b0;
      start_ok <= 1'b0;
      sent     <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state     <= st_send;
            start_ok  <= 1'b1;
            beat_idx  <= 1'b0;
            stall_cnt <= '0;
          end else if (start) begin // Link down
            done <= 1'b1;
            err  <= err_no_rdy;
          end
        end
        st_send: begin
          if (!trn_tdst_rdy_n) begin
            stall_cnt <= '0;
            beat_idx  <= 1'b1;
            if (beat_idx) state <= st_done;
          end else if (stall_limit) begin
            state <= st_idle; // Abandon, not counted as sent
            done  <= 1'b1;
            err   <= err_no_rdy;
          end else begin
            stall_cnt <= stall_cnt + 24'd1;
          end
        end
        st_done: begin
          state <= st_idle;
          done  <= 1'b1;
          sent  <= 1'b1;
          err   <= err_ok;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy = (state != st_idle);

  // Framing decoded from registered state, data holds while stalled
  assign trn_tsrc_rdy_n = (state != st_send);
  assign trn_cyc_n      = (state != st_send);
  assign trn_td         = beat_buf[beat_idx];
  assign trn_tsof_n     = !((state == st_send) && !beat_idx);
  assign trn_teof_n     = !((state == st_send) && beat_idx);
  assign trn_trem_n     = !((state == st_send) && beat_idx && is_4dw_q); // 4DW uses both dwords

endmodule

`default_nettype wire

//--- sources.f
hdl/hm_pkg.sv
hdl/hm_regs.sv
hdl/hm_tx.sv
hdl/hm_stats.sv
hdl/hm_top.sv
tests/hm_tb_assert.sv
tests/hm_tb.sv

//--- tests/hm_golden.txt
// First value is the number of vectors, then one vector per line with columns
// addr len tag nosnoop stall_mode exp_beat0 exp_beat1 exp_trem_n exp_status
9
// 3DW requests, no stalls
0000000012345678 001 05 0 0 00000001011305FF 1234567800000000 1 002
0000000080000040 080 1A 0 0 0000008001131AFF 8000004000000000 1 002
// 4DW requests, no stalls
0000000100000100 010 22 0 0 20000010011322FF 0000000100000100 0 002
FFFF0000ABCDEF00 3FF FF 0 0 200003FF0113FFFF FFFF0000ABCDEF00 0 002
// Random stalls with no snoop
0000000000001000 004 33 1 1 00001004011333FF 0000100000000000 1 002
0000000200000080 020 44 1 1 20001020011344FF 0000000200000080 0 002
// Destination never ready, timeout of 8
0000000000002000 001 55 0 2 0000000000000000 0000000000000000 1 102
// Second start while stalled
0000000000003000 002 66 0 3 00000002011366FF 0000300000000000 1 202
// Clean request after the busy refusal
0000000000004000 008 77 0 0 00000008011377FF 0000400000000000 1 002

//--- tests/hm_tb.sv
`default_nettype none

module hm_tb
  import hm_pkg::*;
();

  localparam int wait_limit = 50;  // Cycles per handshake
  localparam int poll_limit = 200; // Status reads per request

  logic        trn_clk;
  logic        reset;
  logic [7:0]  s_awaddr;
  logic [7:0]  s_araddr;
  logic [31:0] s_wdata;
  logic [31:0] s_rdata;
  logic [3:0]  s_wstrb;
  logic [1:0]  s_bresp;
  logic [1:0]  s_rresp;
  logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic        s_arvalid, s_arready, s_rvalid, s_rready;
  logic [7:0]  cfg_bus_number;
  logic [4:0]  cfg_device_number;
  logic [2:0]  cfg_function_number;
  logic [63:0] trn_td;
  logic        trn_lnk_up_n, trn_tdst_rdy_n, trn_terr_drop_n;
  logic        trn_tsof_n, trn_teof_n, trn_trem_n, trn_tsrc_rdy_n, trn_cyc_n;
  logic        trn_tstr_n, trn_terrfwd_n, trn_tsrc_dsc_n;

  logic [63:0] gold [0:127];
  logic [67:0] beats [$]; // {cyc_n, tsof_n, teof_n, trem_n, td} per transfer
  logic [1:0]  stall_mode;
  logic        hold_stall;
  logic        aborted;
  int          errors;
  int          checks;
  int          exp_start;
  int          exp_done;

  hm_top dut_i (.*);

  always #20 trn_clk = ~trn_clk;

  // Core back-pressure model
  always @(posedge trn_clk) begin
    case (stall_mode)
      2'd0: trn_tdst_rdy_n <= 1'b0;
      2'd1: trn_tdst_rdy_n <= ($urandom % 3) == 0; // About one stall in three
      2'd2: trn_tdst_rdy_n <= 1'b1;
      default: trn_tdst_rdy_n <= hold_stall;
    endcase
  end

  // Beats taken by the core
  always @(posedge trn_clk) begin
    if (!reset && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
      beats.push_back({trn_cyc_n, trn_tsof_n, trn_teof_n, trn_trem_n, trn_td});
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("Timeout: no %s within the allowed cycles, run abandoned", what);
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge trn_clk);
    s_awaddr  <= addr;
    s_wdata   <= data;
    s_awvalid <= 1'b1;
    s_wvalid  <= 1'b1;
    @(posedge trn_clk);
    while (!s_awready && !aborted) begin
      if (n == wait_limit) report_timeout("write address ready");
      else begin
        @(posedge trn_clk);
        n++;
      end
    end
    if (!aborted) check_eq(64'(s_wready), 64'd1, "wready with awready");
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    n = 0;
    @(posedge trn_clk);
    while (!s_bvalid && !aborted) begin
      if (n == wait_limit) report_timeout("write response");
      else begin
        @(posedge trn_clk);
        n++;
      end
    end
    if (!aborted) check_eq(64'(s_bresp), 64'd0, "bresp");
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge trn_clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    @(posedge trn_clk);
    while (!s_arready && !aborted) begin
      if (n == wait_limit) report_timeout("read address ready");
      else begin
        @(posedge trn_clk);
        n++;
      end
    end
    s_arvalid <= 1'b0;
    n = 0;
    @(posedge trn_clk);
    while (!s_rvalid && !aborted) begin
      if (n == wait_limit) report_timeout("read data");
      else begin
        @(posedge trn_clk);
        n++;
      end
    end
    if (!aborted) check_eq(64'(s_rresp), 64'd0, "rresp");
    data = s_rdata;
  endtask

  // Software view of completion, status bit 1
  task automatic wait_done(output logic [31:0] status);
    int n;
    n = 0;
    axi_read(reg_status, status);
    while (!status[1] && !aborted) begin
      if (n == poll_limit) report_timeout("done status");
      else begin
        axi_read(reg_status, status);
        n++;
      end
    end
  endtask

  task automatic pulse_drop(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge trn_clk);
      trn_terr_drop_n <= 1'b0;
    end
    @(posedge trn_clk);
    trn_terr_drop_n <= 1'b1;
  endtask

  task automatic run_test(input int idx);
    int          base;
    int          err_before;
    logic [63:0] addr;
    logic [1:0]  mode;
    logic [31:0] ctrl;
    logic [31:0] rd;
    base       = 1 + 9 * idx;
    err_before = errors;
    addr       = gold[base];
    mode       = gold[base + 4][1:0];
    ctrl       = {30'b0, gold[base + 3][0], 1'b1};
    beats.delete();
    stall_mode <= mode;
    hold_stall <= (mode == 2'd3);
    axi_write(reg_addr_lo, addr[31:0]);
    axi_write(reg_addr_hi, addr[63:32]);
    axi_write(reg_len_tag, {8'b0, gold[base + 2][7:0], 6'b0, gold[base + 1][9:0]});
    axi_write(reg_timeout, (mode == 2'd2) ? 32'd8 : 32'd1000); // Short limit for the abort case
    axi_write(reg_ctrl, ctrl);
    if (mode == 2'd3) begin
      axi_write(reg_ctrl, ctrl); // Lands while the first request is stalled
      hold_stall <= 1'b0;
    end
    wait_done(rd);
    check_eq(64'(rd), gold[base + 8], "status");
    check_eq(64'(beats.size()), (mode == 2'd2) ? 64'd0 : 64'd2, "beat count");
    if (beats.size() == 2) begin
      check_eq(beats[0][63:0], gold[base + 5], "beat 0");
      check_eq(64'(beats[0][66]), 64'd0, "beat 0 tsof_n");
      check_eq(64'(beats[0][65]), 64'd1, "beat 0 teof_n");
      check_eq(64'(beats[0][67]), 64'd0, "beat 0 cyc_n");
      check_eq(beats[1][63:0], gold[base + 6], "beat 1");
      check_eq(64'(beats[1][66]), 64'd1, "beat 1 tsof_n");
      check_eq(64'(beats[1][65]), 64'd0, "beat 1 teof_n");
      check_eq(64'(beats[1][64]), gold[base + 7], "beat 1 trem_n");
      check_eq(64'(beats[1][67]), 64'd0, "beat 1 cyc_n");
    end
    exp_start++;
    if (mode != 2'd2) exp_done++; // Abandoned requests are not sent
    axi_read(reg_cnt_start, rd);
    check_eq(64'(rd), 64'(exp_start), "cnt_start");
    axi_read(reg_cnt_done, rd);
    check_eq(64'(rd), 64'(exp_done), "cnt_done");
    $display("test %0d (stall mode %0d): %s", idx, mode, (errors == err_before) ? "pass" : "fail");
  endtask

  initial begin
    int          n_tests;
    int          err_before;
    logic [31:0] rd;
    trn_clk             = 1'b0;
    reset               = 1'b1;
    s_awaddr            = '0;
    s_awvalid           = 1'b0;
    s_wdata             = '0;
    s_wstrb             = 4'hf;
    s_wvalid            = 1'b0;
    s_bready            = 1'b1;
    s_araddr            = '0;
    s_arvalid           = 1'b0;
    s_rready            = 1'b1;
    cfg_bus_number      = 8'h01;
    cfg_device_number   = 5'h02;
    cfg_function_number = 3'h3; // Requester ID 0x0113
    trn_lnk_up_n        = 1'b0;
    trn_tdst_rdy_n      = 1'b1;
    trn_terr_drop_n     = 1'b1;
    stall_mode          = 2'd0;
    hold_stall          = 1'b0;
    aborted             = 1'b0;
    errors              = 0;
    checks              = 0;
    exp_start           = 0;
    exp_done            = 0;
    void'($urandom(82));
    $readmemh("tests/hm_golden.txt", gold);
    n_tests = int'(gold[0]);
    repeat (10) @(posedge trn_clk);
    reset <= 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    err_before = errors;
    // Idle framing and fixed core controls
    check_eq(64'(trn_cyc_n), 64'd1, "idle trn_cyc_n");
    check_eq(64'(trn_tstr_n), 64'd0, "trn_tstr_n");
    check_eq(64'(trn_terrfwd_n), 64'd1, "trn_terrfwd_n");
    check_eq(64'(trn_tsrc_dsc_n), 64'd1, "trn_tsrc_dsc_n");
    pulse_drop(5);
    pulse_drop(3);
    axi_read(reg_cnt_drop, rd);
    check_eq(64'(rd), 64'(5 + 3), "cnt_drop");
    $display("drop counter and tie-offs: %s", (errors == err_before) ? "pass" : "fail");
    $display("%0d tests, %0d checks, %0d errors", n_tests + 1, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/hm_tb_assert.sv
`default_nettype none

module hm_tb_assert (
  input logic        trn_clk,
  input logic        reset,
  input logic [63:0] trn_td,
  input logic        trn_tsof_n,
  input logic        trn_teof_n,
  input logic        trn_tsrc_rdy_n,
  input logic        trn_tdst_rdy_n
);

  // Frame markers only inside a valid beat
  a_sof_framing: assert property (@(posedge trn_clk) disable iff (reset)
    !trn_tsof_n |-> !trn_tsrc_rdy_n) else $error("tsof_n low while tsrc_rdy_n high");

  a_eof_framing: assert property (@(posedge trn_clk) disable iff (reset)
    !trn_teof_n |-> !trn_tsrc_rdy_n) else $error("teof_n low while tsrc_rdy_n high");

  a_td_hold: assert property (@(posedge trn_clk) disable iff (reset)
    (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=> $stable(trn_td))
    else $error("trn_td changed during a stall");

  a_reset_idle: assert property (@(posedge trn_clk)
    reset |=> trn_tsrc_rdy_n) else $error("tsrc_rdy_n low right after reset");

endmodule

bind hm_tx hm_tb_assert assert_i (.*);

`default_nettype wire
